//--- hdl/nx_node_defines.svh
`ifndef NX_NODE_DEFINES_SVH
`define NX_NODE_DEFINES_SVH

// ====================
// Base sizes
// ====================

// Width of the operation code field
`define NX_OP_W 4

// Number of single-bit scratch registers
`define NX_REG_W 16

// Number of primary inputs and outputs, must not exceed NX_REG_W
`define NX_IO_W 4

// Number of instruction slots
`define NX_SLOTS 32

// ====================
// Derived sizes
// ====================

// Index widths for registers, io bits and slots
`define NX_REG_IDX_W ($clog2(`NX_REG_W))
`define NX_IO_IDX_W ($clog2(`NX_IO_W))
`define NX_STEP_W ($clog2(`NX_SLOTS))

// Opcode, three register indices, output enable, output index
`define NX_INST_W (`NX_OP_W + (3 * `NX_REG_IDX_W) + 1 + `NX_IO_IDX_W)

`endif

//--- hdl/nx_instr_pkg.sv
`include "nx_node_defines.svh"

package nx_instr_pkg;

    // ====================
    // Operations
    // ====================

    // Single-bit boolean operations
    // Codes above op_xnor are legal but produce a zero result
    typedef enum logic [`NX_OP_W-1:0] {
        op_invert = 0,
        op_and    = 1,
        op_nand   = 2,
        op_or     = 3,
        op_nor    = 4,
        op_xor    = 5,
        op_xnor   = 6
    } op_t;

    // ====================
    // Field types
    // ====================

    // Scratch register index
    typedef logic [`NX_REG_IDX_W-1:0] reg_idx_t;

    // Primary input or output bit index
    typedef logic [`NX_IO_IDX_W-1:0] io_idx_t;

    // Instruction word, operation sits in the top bits
    typedef struct packed {
        op_t      op;
        reg_idx_t src_a;
        reg_idx_t src_b;
        reg_idx_t target;
        logic     out_en;
        io_idx_t  out_index;
    } instr_t;

endpackage

//--- hdl/nx_ctrl_pkg.sv
`include "nx_node_defines.svh"

package nx_ctrl_pkg;

    // ====================
    // Node phases
    // ====================

    // Setup takes the program, wait idles until a tick,
    // run walks the slots one per cycle
    typedef enum logic [1:0] {
        ph_setup = 2'd0,
        ph_wait  = 2'd1,
        ph_run   = 2'd2
    } phase_t;

endpackage

//--- hdl/nx_instr_store.sv
`include "nx_node_defines.svh"

module nx_instr_store (
    input  logic                         clk,
    input  logic                         rst,
    // Host program load
    input  nx_instr_pkg::instr_t         load_instr,
    input  logic [`NX_STEP_W-1:0]        load_slot,
    input  logic                         load_valid,
    // Read side, driven by the sequencer
    input  logic [`NX_STEP_W-1:0]        step,
    output nx_instr_pkg::instr_t         slot_instr,
    output logic                         slot_loaded
);

    // ====================
    // Storage
    // ====================

    // Instruction words, contents only matter once the flag is set
    nx_instr_pkg::instr_t slot_mem [`NX_SLOTS];

    // One loaded flag per slot
    logic [`NX_SLOTS-1:0] loaded;

    // Word write on the load strobe
    always_ff @(posedge clk) begin
        if (load_valid) begin
            slot_mem[load_slot] <= load_instr;
        end
    end

    // Flags start clear and are set by any load to the slot
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            loaded <= '0;
        end else if (load_valid) begin
            loaded[load_slot] <= 1'b1;
        end
    end

    // ====================
    // Read port
    // ====================

    // Combinational read at the current step
    assign slot_instr  = slot_mem[step];
    assign slot_loaded = loaded[step];

endmodule

//--- hdl/nx_input_latch.sv
`include "nx_node_defines.svh"

module nx_input_latch (
    input  logic                      clk,
    input  logic                      rst,
    // One bit per strobe
    input  logic                      in_value,
    input  nx_instr_pkg::io_idx_t     in_index,
    input  logic                      in_valid,
    // Current primary input vector
    output logic [`NX_IO_W-1:0]       in_bits
);

    // ====================
    // Input bits
    // ====================

    // Bits keep their value between strobes
    // A strobe in a tick cycle lands after the seed,
    // so the run sees the old value
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_bits <= '0;
        end else if (in_valid) begin
            // Only the indexed bit moves
            in_bits[in_index] <= in_value;
        end
    end

endmodule

//--- hdl/nx_bool_unit.sv
`include "nx_node_defines.svh"

module nx_bool_unit (
    input  logic                      clk,
    input  logic                      rst,
    // Control from the sequencer
    input  logic                      seed,
    input  logic                      exec,
    // Primary inputs used for seeding
    input  logic [`NX_IO_W-1:0]       in_bits,
    // Instruction at the current step
    input  nx_instr_pkg::instr_t      slot_instr,
    // Result and output request
    output logic                      result,
    output logic                      out_en,
    output nx_instr_pkg::io_idx_t     out_index,
    output logic                      out_wr
);

    // ====================
    // Scratch registers
    // ====================

    // One bit per register, low bits hold the seeded inputs
    logic [`NX_REG_W-1:0] regs;

    // Source operand values
    logic value_a;
    logic value_b;

    // ====================
    // Evaluate
    // ====================

    // Sources read straight from the register file
    // The previous instruction's write is already visible here
    assign value_a = regs[slot_instr.src_a];
    assign value_b = regs[slot_instr.src_b];

    always_comb begin
        case (slot_instr.op)
            // Invert ignores the second source
            nx_instr_pkg::op_invert: result = ~value_a;
            nx_instr_pkg::op_and:    result = value_a & value_b;
            nx_instr_pkg::op_nand:   result = ~(value_a & value_b);
            nx_instr_pkg::op_or:     result = value_a | value_b;
            nx_instr_pkg::op_nor:    result = ~(value_a | value_b);
            nx_instr_pkg::op_xor:    result = value_a ^ value_b;
            nx_instr_pkg::op_xnor:   result = ~(value_a ^ value_b);
            // Unused codes give zero
            default:                 result = 1'b0;
        endcase
    end

    // ====================
    // Register update
    // ====================

    // Seed only happens in wait and exec only in run,
    // so the two never collide
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            regs <= '0;
        end else begin
            if (seed) begin
                // Copy primary inputs into the low registers
                regs[`NX_IO_W-1:0] <= in_bits;
            end
            if (exec) begin
                regs[slot_instr.target] <= result;
            end
        end
    end

    // Output request fields
    assign out_en    = slot_instr.out_en;
    assign out_index = slot_instr.out_index;

    // Write only for an executing instruction marked for output
    assign out_wr = exec & slot_instr.out_en;

endmodule

//--- hdl/nx_output_latch.sv
`include "nx_node_defines.svh"

module nx_output_latch (
    input  logic                      clk,
    input  logic                      rst,
    // Write request from the bool unit
    input  logic                      out_wr,
    input  nx_instr_pkg::io_idx_t     out_index,
    input  logic                      result,
    // Primary outputs and their update pulses
    output logic [`NX_IO_W-1:0]       out_values,
    output logic [`NX_IO_W-1:0]       out_valids
);

    // ====================
    // Output register
    // ====================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_values <= '0;
            out_valids <= '0;
        end else begin
            // Pulses last one cycle unless rewritten
            out_valids <= '0;
            if (out_wr) begin
                out_values[out_index] <= result;
                // Flag the updated bit for the next cycle only
                out_valids[out_index] <= 1'b1;
            end
        end
    end

endmodule

//--- hdl/nx_sequencer.sv
`include "nx_node_defines.svh"

module nx_sequencer (
    input  logic                      clk,
    input  logic                      rst,
    // Emulated clock edge and hold
    input  logic                      tick,
    input  logic                      stall,
    // Load strobe, used for the end of setup
    input  logic                      load_valid,
    input  logic                      load_last,
    // Loaded flag of the slot at step
    input  logic                      slot_loaded,
    // Sequencing outputs
    output logic [`NX_STEP_W-1:0]     step,
    output logic                      seed,
    output logic                      exec,
    output nx_ctrl_pkg::phase_t       phase
);

    localparam int unsigned step_w    = `NX_STEP_W;
    localparam int unsigned last_slot = `NX_SLOTS - 1;

    // ====================
    // Cycle decode
    // ====================

    // Run cycle that is allowed to do work
    logic run_go;

    // Ticks count only while waiting
    assign seed = tick && (phase == nx_ctrl_pkg::ph_wait);

    assign run_go = (phase == nx_ctrl_pkg::ph_run) && !stall;

    // Execute only a loaded slot
    assign exec = run_go && slot_loaded;

    // ====================
    // Phase and step
    // ====================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= nx_ctrl_pkg::ph_setup;
            step  <= '0;
        end else begin
            case (phase)
                nx_ctrl_pkg::ph_setup: begin
                    // Last program word closes setup
                    if (load_valid && load_last) begin
                        phase <= nx_ctrl_pkg::ph_wait;
                    end
                end
                nx_ctrl_pkg::ph_wait: begin
                    if (seed) begin
                        phase <= nx_ctrl_pkg::ph_run;
                        step  <= '0;
                    end
                end
                nx_ctrl_pkg::ph_run: begin
                    // Stall holds everything
                    if (run_go) begin
                        if (!slot_loaded) begin
                            // Empty slot ends the program, nothing written
                            phase <= nx_ctrl_pkg::ph_wait;
                        end else if (step == step_w'(last_slot)) begin
                            // Final slot executes then the run stops
                            phase <= nx_ctrl_pkg::ph_wait;
                        end else begin
                            step <= step + step_w'(1);
                        end
                    end
                end
                default: begin
                    phase <= nx_ctrl_pkg::ph_setup;
                end
            endcase
        end
    end

endmodule

//--- hdl/nx_node_core.sv
`include "nx_node_defines.svh"

module nx_node_core (
    input  logic                      clk,
    input  logic                      rst,
    // External controls
    input  logic                      tick,
    input  logic                      stall,
    // Phase flags
    output logic                      in_setup,
    output logic                      in_wait,
    output logic                      in_run,
    // Program load
    input  nx_instr_pkg::instr_t      load_instr,
    input  logic [`NX_STEP_W-1:0]     load_slot,
    input  logic                      load_last,
    input  logic                      load_valid,
    // Input load
    input  logic                      in_value,
    input  nx_instr_pkg::io_idx_t     in_index,
    input  logic                      in_valid,
    // Primary outputs
    output logic [`NX_IO_W-1:0]       out_values,
    output logic [`NX_IO_W-1:0]       out_valids
);

    // ====================
    // Internal wiring
    // ====================

    nx_ctrl_pkg::phase_t      phase;
    logic [`NX_STEP_W-1:0]    step;
    logic                     seed;
    logic                     exec;
    nx_instr_pkg::instr_t     slot_instr;
    logic                     slot_loaded;
    logic [`NX_IO_W-1:0]      in_bits;
    logic                     result;
    nx_instr_pkg::io_idx_t    out_index;
    logic                     out_wr;

    // One-hot phase flags
    assign in_setup = (phase == nx_ctrl_pkg::ph_setup);
    assign in_wait  = (phase == nx_ctrl_pkg::ph_wait);
    assign in_run   = (phase == nx_ctrl_pkg::ph_run);

    // ====================
    // Blocks
    // ====================

    // Phase FSM and step counter
    nx_sequencer u_seq (
        .clk         (clk),
        .rst         (rst),
        .tick        (tick),
        .stall       (stall),
        .load_valid  (load_valid),
        .load_last   (load_last),
        .slot_loaded (slot_loaded),
        .step        (step),
        .seed        (seed),
        .exec        (exec),
        .phase       (phase)
    );

    // Program slots
    nx_instr_store u_store (
        .clk         (clk),
        .rst         (rst),
        .load_instr  (load_instr),
        .load_slot   (load_slot),
        .load_valid  (load_valid),
        .step        (step),
        .slot_instr  (slot_instr),
        .slot_loaded (slot_loaded)
    );

    // Primary inputs
    nx_input_latch u_in (
        .clk      (clk),
        .rst      (rst),
        .in_value (in_value),
        .in_index (in_index),
        .in_valid (in_valid),
        .in_bits  (in_bits)
    );

    // Register file and evaluator
    // The enable bit is already folded into out_wr
    nx_bool_unit u_bool (
        .clk        (clk),
        .rst        (rst),
        .seed       (seed),
        .exec       (exec),
        .in_bits    (in_bits),
        .slot_instr (slot_instr),
        .result     (result),
        .out_en     (),
        .out_index  (out_index),
        .out_wr     (out_wr)
    );

    // Primary outputs with update pulses
    nx_output_latch u_out (
        .clk        (clk),
        .rst        (rst),
        .out_wr     (out_wr),
        .out_index  (out_index),
        .result     (result),
        .out_values (out_values),
        .out_valids (out_valids)
    );

endmodule

//--- verif/tb_nx_node_core.sv
`include "nx_node_defines.svh"

module tb_nx_node_core;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int op_w        = `NX_OP_W;
    localparam int reg_idx_w   = `NX_REG_IDX_W;
    localparam int io_idx_w    = `NX_IO_IDX_W;
    localparam int inst_w      = `NX_INST_W;
    localparam int step_w      = `NX_STEP_W;
    localparam int slots       = `NX_SLOTS;
    localparam int programs    = 40;
    localparam int ticks       = 8;
    localparam int cycle_limit = programs * ticks * (slots + 1) * 2 + 200;

    // Model phase codes
    localparam int s_setup = 0;
    localparam int s_wait  = 1;
    localparam int s_run   = 2;

    logic                 clk;
    logic                 rst;
    logic                 tick;
    logic                 stall;
    logic                 in_setup;
    logic                 in_wait;
    logic                 in_run;
    logic [inst_w-1:0]    load_instr;
    logic [step_w-1:0]    load_slot;
    logic                 load_last;
    logic                 load_valid;
    logic                 in_value;
    logic [io_idx_w-1:0]  in_index;
    logic                 in_valid;
    logic [`NX_IO_W-1:0]  out_values;
    logic [`NX_IO_W-1:0]  out_valids;

    // Reference model state
    int                   m_phase;
    int                   m_step;
    logic [inst_w-1:0]    m_slot [slots];
    logic [slots-1:0]     m_loaded;
    logic [`NX_IO_W-1:0]  m_in;
    logic [`NX_REG_W-1:0] m_regs;
    logic [`NX_IO_W-1:0]  m_out;
    logic [`NX_IO_W-1:0]  m_valid;

    int    mismatch_errors;
    int    other_errors;
    int    cycle_count;
    string test_name;

    nx_node_core u_dut (
        .clk        (clk),
        .rst        (rst),
        .tick       (tick),
        .stall      (stall),
        .in_setup   (in_setup),
        .in_wait    (in_wait),
        .in_run     (in_run),
        .load_instr (load_instr),
        .load_slot  (load_slot),
        .load_last  (load_last),
        .load_valid (load_valid),
        .in_value   (in_value),
        .in_index   (in_index),
        .in_valid   (in_valid),
        .out_values (out_values),
        .out_valids (out_valids)
    );

    always #50 clk = ~clk;

    // ====================
    // Reference model
    // ====================

    // Truth of each operation
    // Unused codes give 0
    function automatic logic apply_op(logic [op_w-1:0] op, logic a, logic b);
        case (op)
            0: return !a;
            1: return a && b;
            2: return !(a && b);
            3: return a || b;
            4: return !(a || b);
            5: return a != b;
            6: return a == b;
            default: return 1'b0;
        endcase
    endfunction

    always @(posedge clk or posedge rst) begin
        logic [inst_w-1:0] w;
        logic              res;
        if (rst) begin
            m_phase  = s_setup;
            m_step   = 0;
            m_loaded = '0;
            m_in     = '0;
            m_regs   = '0;
            m_out    = '0;
            m_valid  = '0;
        end else begin
            w       = m_slot[m_step];
            m_valid = '0;
            if (m_phase == s_run && !stall) begin
                if (!m_loaded[m_step]) begin
                    // Empty slot ends the program
                    m_phase = s_wait;
                end else begin
                    // Fields from the top are op, a, b, target, enable and index
                    res = apply_op(w[inst_w-1 -: op_w],
                                   m_regs[w[io_idx_w + 1 + 2 * reg_idx_w +: reg_idx_w]],
                                   m_regs[w[io_idx_w + 1 + reg_idx_w +: reg_idx_w]]);
                    m_regs[w[io_idx_w + 1 +: reg_idx_w]] = res;
                    if (w[io_idx_w]) begin
                        m_out[w[io_idx_w-1:0]]   = res;
                        m_valid[w[io_idx_w-1:0]] = 1'b1;
                    end
                    if (m_step == slots - 1) begin
                        m_phase = s_wait;
                    end else begin
                        m_step++;
                    end
                end
            end else if (m_phase == s_wait && tick) begin
                // Seed sees the inputs from before this edge
                m_regs[`NX_IO_W-1:0] = m_in;
                m_phase = s_run;
                m_step  = 0;
            end else if (m_phase == s_setup && load_valid && load_last) begin
                m_phase = s_wait;
            end
            // Loads and input strobes land after execution reads
            if (load_valid) begin
                m_slot[load_slot]   = load_instr;
                m_loaded[load_slot] = 1'b1;
            end
            if (in_valid) begin
                m_in[in_index] = in_value;
            end
        end
    end

    // ====================
    // Checks
    // ====================

    task automatic report_mismatch(string what, int expected, int actual);
        $display("MISMATCH %s %s expected %0h actual %0h", test_name, what, expected, actual);
        mismatch_errors++;
    endtask

    // Compare every cycle in the stable half of the clock
    always @(negedge clk) begin
        logic [2:0] exp_flags;
        if (!rst) begin
            exp_flags = {m_phase == s_setup, m_phase == s_wait, m_phase == s_run};
            if (out_values !== m_out) begin
                report_mismatch("out_values", m_out, out_values);
            end
            if (out_valids !== m_valid) begin
                report_mismatch("out_valids", m_valid, out_valids);
            end
            if ({in_setup, in_wait, in_run} !== exp_flags) begin
                report_mismatch("phase flags", exp_flags, {in_setup, in_wait, in_run});
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Run stopped after %0d cycles without finishing", cycle_limit);
            $display("Errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
            $display("Checks failed");
            $finish;
        end
    end

    // ====================
    // Stimulus
    // ====================

    function automatic logic [inst_w-1:0] rand_instr();
        logic [op_w-1:0] op;
        // Mostly real operations with some unused codes
        if (($urandom % 5) == 0) begin
            op = op_w'(7 + $urandom % 9);
        end else begin
            op = op_w'($urandom % 7);
        end
        return {op, reg_idx_w'($urandom), reg_idx_w'($urandom), reg_idx_w'($urandom),
                1'($urandom), io_idx_w'($urandom)};
    endfunction

    task automatic reset_node();
        @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    endtask

    // Slots 0 to n-1 in order with a tick midway that must be ignored
    task automatic load_program(int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            load_valid <= 1'b1;
            load_slot  <= step_w'(i);
            load_instr <= rand_instr();
            load_last  <= (i == n - 1);
            tick       <= (i == n / 2);
        end
        @(posedge clk);
        load_valid <= 1'b0;
        load_last  <= 1'b0;
        tick       <= 1'b0;
        @(negedge clk);
        if (!in_wait) begin
            $display("Phase did not reach wait after the last load in test %s", test_name);
            other_errors++;
        end
    endtask

    // Rewrites keep slots 0 to n-1 loaded
    task automatic rewrite_slots(int n);
        int count;
        count = $urandom % 3;
        repeat (count) begin
            @(posedge clk);
            load_valid <= 1'b1;
            load_slot  <= step_w'($urandom % n);
            load_instr <= rand_instr();
            load_last  <= 1'($urandom);
        end
        @(posedge clk);
        load_valid <= 1'b0;
        load_last  <= 1'b0;
    endtask

    task automatic change_inputs();
        int count;
        count = $urandom % 4;
        repeat (count) begin
            @(posedge clk);
            in_valid <= 1'b1;
            in_index <= io_idx_w'($urandom % `NX_IO_W);
            in_value <= 1'($urandom);
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    // One tick with random stalls and stray ticks, then the run length check
    task automatic run_once(int n);
        int   run_cycles;
        int   stalled;
        int   base;
        logic running;
        logic more;
        run_cycles = 0;
        stalled    = 0;
        base       = (n < slots) ? n + 1 : slots;
        @(posedge clk);
        tick     <= 1'b1;
        in_valid <= 1'($urandom);
        in_index <= io_idx_w'($urandom % `NX_IO_W);
        in_value <= 1'($urandom);
        @(posedge clk);
        tick     <= 1'b0;
        in_valid <= 1'b0;
        stall    <= (($urandom % 4) == 0);
        running = 1'b1;
        while (running) begin
            @(negedge clk);
            running = in_run;
            if (running) begin
                run_cycles++;
                if (stall) begin
                    stalled++;
                end
            end
            // Only stall or tick while the next cycle is still in run
            more = running && (run_cycles - stalled < base);
            @(posedge clk);
            stall <= more && (($urandom % 4) == 0);
            tick  <= more && (($urandom % 8) == 0);
        end
        if (run_cycles != base + stalled) begin
            report_mismatch("run length", base + stalled, run_cycles);
        end
    endtask

    initial begin
        int n;
        void'($urandom(32'h88e9));
        clk         = 1'b0;
        rst         = 1'b1;
        tick        = 1'b0;
        stall       = 1'b0;
        load_instr  = '0;
        load_slot   = '0;
        load_last   = 1'b0;
        load_valid  = 1'b0;
        in_value    = 1'b0;
        in_index    = '0;
        in_valid    = 1'b0;
        cycle_count = 0;
        test_name   = "reset";
        for (int p = 0; p < programs; p++) begin
            test_name = "reset";
            reset_node();
            @(negedge clk);
            if ({in_setup, in_wait, in_run} !== 3'b100) begin
                report_mismatch("phase after reset", 3'b100, {in_setup, in_wait, in_run});
            end
            if (out_values !== '0 || out_valids !== '0) begin
                report_mismatch("outputs after reset", 0, {out_values, out_valids});
            end
            // Every fourth program fills all slots
            n = ((p % 4) == 3) ? slots : 1 + $urandom % (slots - 1);
            test_name = "load";
            load_program(n);
            for (int t = 0; t < ticks; t++) begin
                test_name = (n == slots) ? "full" : "run";
                if (t > 0) begin
                    test_name = "reload";
                    rewrite_slots(n);
                end
                change_inputs();
                run_once(n);
            end
        end
        $display("Errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+hdl
hdl/nx_instr_pkg.sv
hdl/nx_ctrl_pkg.sv
hdl/nx_instr_store.sv
hdl/nx_input_latch.sv
hdl/nx_bool_unit.sv
hdl/nx_output_latch.sv
hdl/nx_sequencer.sv
hdl/nx_node_core.sv
verif/tb_nx_node_core.sv
